// File: bench/fv_bank_tb.sv
/* feature bank testbench */

`include "fv_defs.svh"

module fv_bank_tb;

    import fv_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_PE = `NUM_EDGE_PE;
    localparam int LPN = `LINES_PER_NODE;
    localparam int SINGLE_READS = 8;
    localparam int PE_ROUNDS = 3;
    localparam int ITER_PASSES = `NUM_REPLAY_ITER;
    // writes, edge reads, replay streams plus buffer reads
    localparam int TOTAL_BEATS = 1 + `SRAM_DEPTH + SINGLE_READS * LPN
        + PE_ROUNDS * NUM_PE * LPN + ITER_PASSES * 2 * `NODE_PER_ITER * LPN;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40;
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic reset;
    logic [NUM_PE-1:0] rd_req;
    node_id_t [NUM_PE-1:0] rd_node_id;
    logic [NUM_PE-1:0] rd_ack;
    logic wb_req;
    node_id_t wb_node_id;
    line_t wb_line;
    fv_data_t wb_data;
    logic wb_ack;
    logic rd_valid;
    logic rd_sos;
    logic rd_eos;
    fv_data_t rd_data;
    pe_tag_t rd_pe_tag;
    replay_iter_t replay_iter;
    logic update_iter;
    fv_cnt_t fv_num;
    logic stream_begin;
    sm_addr_t sm_rd_addr;
    fv_data_t sm_rd_data;
    logic sm_ready;

    // bank shadow updated on every acknowledged write
    fv_data_t shadow [`SRAM_DEPTH];
    fv_data_t got_line [NUM_PE][LPN];
    int got_cnt [NUM_PE];
    int done_cnt [NUM_PE];
    node_id_t exp_node [NUM_PE];
    logic stream_open;
    // tag of the most recently closed read stream
    pe_tag_t done_tag;
    int error_cnt;
    int check_cnt;
    int test_cnt;
    int test_fail_cnt;
    int test_err_base;

    fv_bank_top u_fv_bank_top (
        .clk(clk), .reset(reset),
        .rd_req(rd_req), .rd_node_id(rd_node_id), .rd_ack(rd_ack),
        .wb_req(wb_req), .wb_node_id(wb_node_id), .wb_line(wb_line),
        .wb_data(wb_data), .wb_ack(wb_ack),
        .rd_valid(rd_valid), .rd_sos(rd_sos), .rd_eos(rd_eos),
        .rd_data(rd_data), .rd_pe_tag(rd_pe_tag),
        .replay_iter(replay_iter), .update_iter(update_iter),
        .fv_num(fv_num), .stream_begin(stream_begin),
        .sm_rd_addr(sm_rd_addr), .sm_rd_data(sm_rd_data), .sm_ready(sm_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // line address is node id followed by line within node
    function automatic fv_data_t ref_line(input node_id_t node, input line_t line);
        return shadow[{node, line}];
    endfunction

    function automatic fv_cnt_t random_fv_num();
        return fv_cnt_t'(2 * $urandom_range(8, 1));
    endfunction

    task automatic check_line(input fv_data_t got, input fv_data_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input pe_tag_t got, input pe_tag_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %0t: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic start_test();
        test_err_base = error_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (error_cnt == test_err_base) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_err_base);
        end
    endtask

    // inputs change shortly after the rising edge
    task automatic next_drive();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_write_back(input node_id_t node, input line_t line,
                                     input fv_data_t data);
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            error_cnt++;
            $display("write-back to node %0d line %0d was never acknowledged", node, line);
        end else begin
            shadow[{node, line}] = data;
        end
        next_drive();
        wb_req = 1'b0;
        repeat (2) @(negedge clk);
        check_flag(wb_ack, 1'b0, "wb_ack one cycle after req drop");
    endtask

    task automatic write_back(input node_id_t node, input line_t line, input fv_data_t data);
        next_drive();
        check_flag(wb_ack, 1'b0, "wb_ack before request");
        wb_node_id = node;
        wb_line = line;
        wb_data = data;
        wb_req = 1'b1;
        finish_write_back(node, line, data);
    endtask

    task automatic edge_read(input int pe, input node_id_t node);
        int n;
        int done_before;
        next_drive();
        check_flag(rd_ack[pe], 1'b0, $sformatf("rd_ack[%0d] before request", pe));
        exp_node[pe] = node;
        done_before = done_cnt[pe];
        rd_node_id[pe] = node;
        rd_req[pe] = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rd_ack[pe] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rd_ack[pe]) begin
            error_cnt++;
            $display("read of node %0d by pe %0d was never acknowledged", node, pe);
        end else begin
            // the stream that closed just before this ack belongs to this pe
            check_tag(done_tag, pe_tag_t'(pe),
                      $sformatf("tag of the stream acknowledged to pe %0d", pe));
        end
        check_count(done_cnt[pe] - done_before, 1, $sformatf("streams served to pe %0d", pe));
        next_drive();
        rd_req[pe] = 1'b0;
        repeat (2) @(negedge clk);
        check_flag(rd_ack[pe], 1'b0, $sformatf("rd_ack[%0d] one cycle after req drop", pe));
    endtask

    task automatic compare_stream(input pe_tag_t tag);
        int lines;
        lines = int'(fv_num) / 2;
        check_count(got_cnt[tag], lines, $sformatf("beats to pe %0d", tag));
        for (int i = 0; i < lines && i < got_cnt[tag]; i++) begin
            check_line(got_line[tag][i], ref_line(exp_node[tag], line_t'(i)),
                       $sformatf("pe %0d node %0d line %0d", tag, exp_node[tag], i));
        end
    endtask

    // collects read beats per tag and compares at eos
    always @(negedge clk) begin
        if (!reset && rd_valid) begin
            check_flag(rd_req[rd_pe_tag], 1'b1, "beat tag has an open request");
            if (rd_sos) begin
                check_flag(stream_open, 1'b0, "sos while another stream is open");
                stream_open = 1'b1;
                got_cnt[rd_pe_tag] = 0;
            end else begin
                check_flag(stream_open, 1'b1, "beat outside a stream");
            end
            if (got_cnt[rd_pe_tag] < LPN) begin
                got_line[rd_pe_tag][got_cnt[rd_pe_tag]] = rd_data;
            end
            got_cnt[rd_pe_tag]++;
            if (rd_eos) begin
                compare_stream(rd_pe_tag);
                stream_open = 1'b0;
                done_tag = rd_pe_tag;
                done_cnt[rd_pe_tag]++;
            end
        end
    end

    task automatic check_iter_block(input replay_iter_t iter);
        int n;
        int lines;
        next_drive();
        fv_num = random_fv_num();
        replay_iter = iter;
        // ready from the last block stays up until the new sos
        n = 0;
        @(negedge clk);
        while (sm_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (sm_ready) begin
            error_cnt++;
            $display("sm_ready did not drop when the stream for replay iteration %0d began",
                     iter);
        end
        while (!sm_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!sm_ready) begin
            error_cnt++;
            $display("small buffer never became ready for replay iteration %0d", iter);
        end
        lines = int'(fv_num) / 2;
        for (int nb = 0; nb < `NODE_PER_ITER; nb++) begin
            for (int ln = 0; ln < lines; ln++) begin
                next_drive();
                sm_rd_addr = sm_addr_t'(nb * LPN + ln);
                @(negedge clk);
                check_line(sm_rd_data,
                           ref_line(node_id_t'(int'(iter) * `NODE_PER_ITER + nb), line_t'(ln)),
                           $sformatf("buffer iter %0d node %0d line %0d", iter, nb, ln));
            end
        end
    endtask

    initial begin
        void'($urandom(32'hed15_5f62));
        error_cnt = 0;
        check_cnt = 0;
        test_cnt = 0;
        test_fail_cnt = 0;
        test_err_base = 0;
        reset = 1'b1;
        rd_req = '0;
        rd_node_id = '0;
        wb_req = 1'b0;
        wb_node_id = '0;
        wb_line = '0;
        wb_data = '0;
        replay_iter = '0;
        update_iter = 1'b0;
        fv_num = fv_cnt_t'(16);
        stream_begin = 1'b0;
        sm_rd_addr = '0;
        stream_open = 1'b0;
        done_tag = '0;
        for (int i = 0; i < NUM_PE; i++) begin
            got_cnt[i] = 0;
            done_cnt[i] = 0;
            exp_node[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);

        start_test();
        check_flag(rd_valid, 1'b0, "rd_valid after reset");
        check_flag(sm_ready, 1'b0, "sm_ready after reset");
        check_flag(wb_ack, 1'b0, "wb_ack after reset");
        check_count(int'(rd_ack), 0, "rd_ack after reset");
        next_drive();
        wb_node_id = node_id_t'(5);
        wb_line = line_t'(3);
        wb_data = {$urandom, $urandom};
        wb_req = 1'b1;
        // held off until update_iter turns odd
        repeat (20) begin
            @(negedge clk);
            check_flag(wb_ack, 1'b0, "wb_ack while update_iter even");
        end
        next_drive();
        update_iter = 1'b1;
        finish_write_back(wb_node_id, wb_line, wb_data);
        end_test("reset and blocked request");

        start_test();
        for (int nd = 0; nd < `NUM_NODES; nd++) begin
            for (int ln = 0; ln < LPN; ln++) begin
                write_back(node_id_t'(nd), line_t'(ln), {$urandom, $urandom});
            end
        end
        end_test("write-back to all nodes");

        start_test();
        for (int i = 0; i < SINGLE_READS; i++) begin
            next_drive();
            fv_num = random_fv_num();
            edge_read(int'($urandom_range(NUM_PE - 1, 0)),
                      node_id_t'($urandom_range(`NUM_NODES - 1, 0)));
        end
        end_test("single edge-pe reads");

        start_test();
        for (int r = 0; r < PE_ROUNDS; r++) begin
            next_drive();
            fv_num = random_fv_num();
            fork
                edge_read(0, node_id_t'($urandom_range(`NUM_NODES - 1, 0)));
                edge_read(1, node_id_t'($urandom_range(`NUM_NODES - 1, 0)));
                edge_read(2, node_id_t'($urandom_range(`NUM_NODES - 1, 0)));
                edge_read(3, node_id_t'($urandom_range(`NUM_NODES - 1, 0)));
            join
        end
        end_test("concurrent edge-pe reads");

        start_test();
        next_drive();
        update_iter = 1'b0;
        for (int it = 1; it <= ITER_PASSES; it++) begin
            check_iter_block(replay_iter_t'(it % `NUM_REPLAY_ITER));
        end
        end_test("replay stream to small buffer");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: include/fv_defs.svh
/* feature-value bank sizes */

`ifndef FV_DEFS_SVH
`define FV_DEFS_SVH

// one sram line carries two features
`define FV_WIDTH 64

// largest feature count per node
`define MAX_FV_NUM 16

// nodes in one replay iteration block
`define NODE_PER_ITER 4

`define NUM_REPLAY_ITER 4

// edge pes sharing the bank
`define NUM_EDGE_PE 4

// derived sizes
`define LINES_PER_NODE (`MAX_FV_NUM / 2)
`define NUM_NODES (`NODE_PER_ITER * `NUM_REPLAY_ITER)
`define SRAM_DEPTH (`NUM_NODES * `LINES_PER_NODE)

`endif

// File: rtl/fv_bank_cntl.sv
/* feature bank controller */

`include "fv_defs.svh"

module fv_bank_cntl (
    input  logic                 clk,
    input  logic                 reset,
    input  fv_pkg::replay_iter_t replay_iter,
    input  logic                 update_iter,
    input  fv_pkg::fv_cnt_t      fv_num,
    input  logic                 stream_begin,
    input  logic                 req_valid,
    input  logic                 req_rd_wr,
    input  fv_pkg::node_id_t     req_node_id,
    input  fv_pkg::line_t        req_line,
    input  fv_pkg::fv_data_t     req_data,
    input  fv_pkg::pe_tag_t      req_pe_tag,
    output logic                 req_done,
    output logic                 cen,
    output logic                 wen,
    output fv_pkg::fv_addr_t     addr,
    output fv_pkg::fv_data_t     wdata,
    input  fv_pkg::fv_data_t     rdata,
    output logic                 sm_valid,
    output logic                 sm_sos,
    output logic                 sm_eos,
    output fv_pkg::sm_addr_t     sm_addr,
    output fv_pkg::fv_data_t     sm_data,
    output logic                 rd_valid,
    output logic                 rd_sos,
    output logic                 rd_eos,
    output fv_pkg::fv_data_t     rd_data,
    output fv_pkg::pe_tag_t      rd_pe_tag
);

    import fv_pkg::*;

    localparam int NODE_W = $clog2(`NODE_PER_ITER);

    cntl_state_t state;
    cntl_state_t nx_state;
    line_t line_cnt;
    line_t nx_line_cnt;
    logic [NODE_W-1:0] node_cnt;
    logic [NODE_W-1:0] nx_node_cnt;
    logic issue_done;
    logic nx_issue_done;
    replay_iter_t cur_iter;
    fv_cnt_t total_fv;
    pe_tag_t pe_tag;
    fv_addr_t prev_addr;
    line_t last_line;
    fv_addr_t stream_addr;
    fv_addr_t edge_addr;
    logic stream_go;
    logic req_go;
    logic beat_pend;
    logic first_beat;
    logic stream_beat;
    logic edge_beat;

    // stream on an explicit begin or a new replay iteration
    assign stream_go = !update_iter && (stream_begin || (replay_iter != cur_iter));
    assign req_go = update_iter && req_valid;

    assign last_line = line_t'((total_fv >> 1) - 1'b1);
    assign stream_addr = {cur_iter, node_cnt, line_cnt};
    assign edge_addr = {req_node_id, line_cnt};

    // a read issued last cycle has its data on rdata now
    assign stream_beat = (state == stream_iter) && beat_pend;
    assign edge_beat = (state == rd_to_edge) && beat_pend;

    always_comb begin
        nx_state = state;
        nx_line_cnt = line_cnt;
        nx_node_cnt = node_cnt;
        nx_issue_done = issue_done;
        cen = 1'b1;
        wen = 1'b1;
        addr = stream_addr;
        wdata = req_data;
        req_done = 1'b0;

        case (state)
            idle: begin
                nx_line_cnt = '0;
                nx_node_cnt = '0;
                nx_issue_done = 1'b0;
                if (stream_go) begin
                    nx_state = stream_iter;
                end else if (req_go) begin
                    nx_state = req_rd_wr ? wb_write : rd_to_edge;
                end
            end
            stream_iter: begin
                if (!issue_done) begin
                    cen = 1'b0;
                    addr = stream_addr;
                    if (line_cnt == last_line) begin
                        nx_line_cnt = '0;
                        if (node_cnt == NODE_W'(`NODE_PER_ITER - 1)) begin
                            nx_issue_done = 1'b1;
                        end else begin
                            nx_node_cnt = node_cnt + 1'b1;
                        end
                    end else begin
                        nx_line_cnt = line_cnt + 1'b1;
                    end
                end else begin
                    // last beat leaves this cycle
                    nx_state = idle;
                end
            end
            wb_write: begin
                cen = 1'b0;
                wen = 1'b0;
                addr = {req_node_id, req_line};
                req_done = 1'b1;
                nx_state = idle;
            end
            rd_to_edge: begin
                if (!issue_done) begin
                    cen = 1'b0;
                    addr = edge_addr;
                    if (line_cnt == last_line) begin
                        nx_issue_done = 1'b1;
                    end else begin
                        nx_line_cnt = line_cnt + 1'b1;
                    end
                end else if (!beat_pend) begin
                    // eos is on rd_* now, hand back to the arbiter
                    req_done = 1'b1;
                    nx_state = idle;
                end
            end
            default: nx_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            line_cnt <= '0;
            node_cnt <= '0;
            issue_done <= 1'b0;
            beat_pend <= 1'b0;
            first_beat <= 1'b0;
            cur_iter <= '0;
            total_fv <= '0;
            pe_tag <= '0;
            sm_valid <= 1'b0;
            sm_sos <= 1'b0;
            sm_eos <= 1'b0;
            rd_valid <= 1'b0;
            rd_sos <= 1'b0;
            rd_eos <= 1'b0;
        end else begin
            state <= nx_state;
            line_cnt <= nx_line_cnt;
            node_cnt <= nx_node_cnt;
            issue_done <= nx_issue_done;
            beat_pend <= !cen && wen;
            if (state == idle) begin
                first_beat <= 1'b1;
                total_fv <= fv_num;
            end else if (beat_pend) begin
                first_beat <= 1'b0;
            end
            if (state == idle && stream_go) begin
                cur_iter <= replay_iter;
            end
            if (state == idle && req_go) begin
                pe_tag <= req_pe_tag;
            end
            sm_valid <= stream_beat;
            sm_sos <= stream_beat && first_beat;
            sm_eos <= stream_beat && issue_done;
            rd_valid <= edge_beat;
            rd_sos <= edge_beat && first_beat;
            rd_eos <= edge_beat && issue_done;
        end
    end

    // beat payload, address trails the read by one cycle
    always_ff @(posedge clk) begin
        prev_addr <= addr;
        if (stream_beat) begin
            sm_addr <= sm_addr_t'(prev_addr);
            sm_data <= rdata;
        end
        if (edge_beat) begin
            rd_data <= rdata;
            rd_pe_tag <= pe_tag;
        end
    end

endmodule

// File: rtl/fv_bank_top.sv
/* feature bank top */

`include "fv_defs.svh"

module fv_bank_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [`NUM_EDGE_PE-1:0]             rd_req,
    input  fv_pkg::node_id_t [`NUM_EDGE_PE-1:0] rd_node_id,
    output logic [`NUM_EDGE_PE-1:0]             rd_ack,
    input  logic                                wb_req,
    input  fv_pkg::node_id_t                    wb_node_id,
    input  fv_pkg::line_t                       wb_line,
    input  fv_pkg::fv_data_t                    wb_data,
    output logic                                wb_ack,
    output logic                                rd_valid,
    output logic                                rd_sos,
    output logic                                rd_eos,
    output fv_pkg::fv_data_t                    rd_data,
    output fv_pkg::pe_tag_t                     rd_pe_tag,
    input  fv_pkg::replay_iter_t                replay_iter,
    input  logic                                update_iter,
    input  fv_pkg::fv_cnt_t                     fv_num,
    input  logic                                stream_begin,
    input  fv_pkg::sm_addr_t                    sm_rd_addr,
    output fv_pkg::fv_data_t                    sm_rd_data,
    output logic                                sm_ready
);

    import fv_pkg::*;

    // arbiter to controller
    logic req_valid;
    logic req_rd_wr;
    node_id_t req_node_id;
    line_t req_line;
    fv_data_t req_data;
    pe_tag_t req_pe_tag;
    logic req_done;

    // controller to sram
    logic cen;
    logic wen;
    fv_addr_t addr;
    fv_data_t wdata;
    fv_data_t rdata;

    // replay stream into the small buffer
    logic sm_valid;
    logic sm_sos;
    logic sm_eos;
    sm_addr_t sm_addr;
    fv_data_t sm_data;

    fv_req_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .rd_req(rd_req), .rd_node_id(rd_node_id), .rd_ack(rd_ack),
        .wb_req(wb_req), .wb_node_id(wb_node_id), .wb_line(wb_line),
        .wb_data(wb_data), .wb_ack(wb_ack),
        .req_valid(req_valid), .req_rd_wr(req_rd_wr), .req_node_id(req_node_id),
        .req_line(req_line), .req_data(req_data), .req_pe_tag(req_pe_tag),
        .req_done(req_done)
    );

    fv_bank_cntl u_cntl (
        .clk(clk), .reset(reset),
        .replay_iter(replay_iter), .update_iter(update_iter),
        .fv_num(fv_num), .stream_begin(stream_begin),
        .req_valid(req_valid), .req_rd_wr(req_rd_wr), .req_node_id(req_node_id),
        .req_line(req_line), .req_data(req_data), .req_pe_tag(req_pe_tag),
        .req_done(req_done),
        .cen(cen), .wen(wen), .addr(addr), .wdata(wdata), .rdata(rdata),
        .sm_valid(sm_valid), .sm_sos(sm_sos), .sm_eos(sm_eos),
        .sm_addr(sm_addr), .sm_data(sm_data),
        .rd_valid(rd_valid), .rd_sos(rd_sos), .rd_eos(rd_eos),
        .rd_data(rd_data), .rd_pe_tag(rd_pe_tag)
    );

    fv_sram_bank u_sram (
        .clk(clk), .cen(cen), .wen(wen), .addr(addr), .wdata(wdata), .rdata(rdata)
    );

    fv_small_buffer u_small_buf (
        .clk(clk), .reset(reset),
        .sm_valid(sm_valid), .sm_sos(sm_sos), .sm_eos(sm_eos),
        .sm_addr(sm_addr), .sm_data(sm_data),
        .sm_rd_addr(sm_rd_addr), .sm_rd_data(sm_rd_data), .sm_ready(sm_ready)
    );

endmodule

// File: rtl/fv_pkg.sv
/* feature-value bank types */

`include "fv_defs.svh"

package fv_pkg;

    typedef logic [`FV_WIDTH-1:0] fv_data_t;

    // {replay iter, node in block, line}, the top two fields form the node id
    typedef logic [$clog2(`SRAM_DEPTH)-1:0] fv_addr_t;

    typedef logic [$clog2(`NUM_NODES)-1:0] node_id_t;
    typedef logic [$clog2(`LINES_PER_NODE)-1:0] line_t;

    // feature count, 2 to 16
    typedef logic [$clog2(`MAX_FV_NUM):0] fv_cnt_t;

    typedef logic [$clog2(`NUM_REPLAY_ITER)-1:0] replay_iter_t;
    typedef logic [$clog2(`NUM_EDGE_PE)-1:0] pe_tag_t;

    // {node in block, line}
    typedef logic [$clog2(`NODE_PER_ITER * `LINES_PER_NODE)-1:0] sm_addr_t;

    typedef enum logic [1:0] {
        idle        = 2'd0,
        stream_iter = 2'd1,
        wb_write    = 2'd2,
        rd_to_edge  = 2'd3
    } cntl_state_t;

endpackage

// File: rtl/fv_req_arbiter.sv
/* round-robin four-phase request arbiter */

`include "fv_defs.svh"

module fv_req_arbiter (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [`NUM_EDGE_PE-1:0]                  rd_req,
    input  fv_pkg::node_id_t [`NUM_EDGE_PE-1:0]      rd_node_id,
    output logic [`NUM_EDGE_PE-1:0]                  rd_ack,
    input  logic                                     wb_req,
    input  fv_pkg::node_id_t                         wb_node_id,
    input  fv_pkg::line_t                            wb_line,
    input  fv_pkg::fv_data_t                         wb_data,
    output logic                                     wb_ack,
    output logic                                     req_valid,
    output logic                                     req_rd_wr,
    output fv_pkg::node_id_t                         req_node_id,
    output fv_pkg::line_t                            req_line,
    output fv_pkg::fv_data_t                         req_data,
    output fv_pkg::pe_tag_t                          req_pe_tag,
    input  logic                                     req_done
);

    import fv_pkg::*;

    // write-back port sits above the edge pes
    localparam int NUM_REQ = `NUM_EDGE_PE + 1;
    localparam int IDX_W = $clog2(NUM_REQ);
    localparam int WB_IDX = `NUM_EDGE_PE;

    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_busy = 2'd1,
        arb_ack  = 2'd2
    } arb_state_t;

    arb_state_t state;
    logic [NUM_REQ-1:0] req_vec;
    logic [NUM_REQ-1:0] ack_vec;
    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] gnt_idx;
    logic [IDX_W-1:0] pick_idx;
    logic pick_found;

    function automatic logic [IDX_W-1:0] wrap_idx(input logic [IDX_W-1:0] base,
                                                  input int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= NUM_REQ) begin
            sum = sum - NUM_REQ;
        end
        return IDX_W'(sum);
    endfunction

    assign req_vec = {wb_req, rd_req};
    assign rd_ack = ack_vec[`NUM_EDGE_PE-1:0];
    assign wb_ack = ack_vec[WB_IDX];

    // first active requester at or after ptr
    always_comb begin
        pick_found = 1'b0;
        pick_idx = ptr;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (!pick_found && req_vec[wrap_idx(ptr, i)]) begin
                pick_found = 1'b1;
                pick_idx = wrap_idx(ptr, i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
            ptr <= '0;
            gnt_idx <= '0;
            ack_vec <= '0;
            req_valid <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (pick_found) begin
                        gnt_idx <= pick_idx;
                        req_valid <= 1'b1;
                        state <= arb_busy;
                    end
                end
                arb_busy: begin
                    if (req_done) begin
                        req_valid <= 1'b0;
                        ack_vec[gnt_idx] <= 1'b1;
                        state <= arb_ack;
                    end
                end
                arb_ack: begin
                    // return to zero, then rotate past the winner
                    if (!req_vec[gnt_idx]) begin
                        ack_vec <= '0;
                        ptr <= wrap_idx(gnt_idx, 1);
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // request fields held from grant to req_done
    always_ff @(posedge clk) begin
        if (state == arb_idle && pick_found) begin
            req_rd_wr <= (pick_idx == IDX_W'(WB_IDX));
            if (pick_idx == IDX_W'(WB_IDX)) begin
                req_node_id <= wb_node_id;
                req_line <= wb_line;
                req_data <= wb_data;
                req_pe_tag <= '0;
            end else begin
                req_node_id <= rd_node_id[pe_tag_t'(pick_idx)];
                req_line <= '0;
                req_data <= '0;
                req_pe_tag <= pe_tag_t'(pick_idx);
            end
        end
    end

endmodule

// File: rtl/fv_small_buffer.sv
/* small feature buffer */

`include "fv_defs.svh"

module fv_small_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             sm_valid,
    input  logic             sm_sos,
    input  logic             sm_eos,
    input  fv_pkg::sm_addr_t sm_addr,
    input  fv_pkg::fv_data_t sm_data,
    input  fv_pkg::sm_addr_t sm_rd_addr,
    output fv_pkg::fv_data_t sm_rd_data,
    output logic             sm_ready
);

    import fv_pkg::*;

    localparam int SM_DEPTH = `NODE_PER_ITER * `LINES_PER_NODE;

    fv_data_t buf_mem [SM_DEPTH];

    // set between sos and eos of one stream
    logic in_stream;

    always_ff @(posedge clk) begin
        if (sm_valid) begin
            buf_mem[sm_addr] <= sm_data;
        end
    end

    // combinational read port
    assign sm_rd_data = buf_mem[sm_rd_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream <= 1'b0;
            sm_ready <= 1'b0;
        end else if (sm_valid) begin
            if (sm_eos) begin
                // only a stream that began here counts as landed
                sm_ready <= in_stream || sm_sos;
                in_stream <= 1'b0;
            end else if (sm_sos) begin
                sm_ready <= 1'b0;
                in_stream <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/fv_sram_bank.sv
/* single-port feature sram */

`include "fv_defs.svh"

module fv_sram_bank (
    input  logic             clk,
    input  logic             cen,
    input  logic             wen,
    input  fv_pkg::fv_addr_t addr,
    input  fv_pkg::fv_data_t wdata,
    output fv_pkg::fv_data_t rdata
);

    import fv_pkg::*;

    fv_data_t mem [`SRAM_DEPTH];

    // write completes at the edge
    always_ff @(posedge clk) begin
        if (!cen && !wen) begin
            mem[addr] <= wdata;
        end
    end

    // read data valid one cycle after the access
    always_ff @(posedge clk) begin
        if (!cen && wen) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the feature bank testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module fv_bank_tb \
    --Mdir obj_dir -o fv_bank_sim

./obj_dir/fv_bank_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: vlog.f
+incdir+include
rtl/fv_pkg.sv
rtl/fv_sram_bank.sv
rtl/fv_req_arbiter.sv
rtl/fv_bank_cntl.sv
rtl/fv_small_buffer.sv
rtl/fv_bank_top.sv
bench/fv_bank_tb.sv
